/* hw/vdp_bus_pkg.sv */
`default_nettype none

package vdp_bus_pkg;

  // host register port
  localparam int csr_addr_width = 3;
  localparam int csr_data_width = 64;

  // register map
  localparam logic [csr_addr_width-1:0] csr_a_ptr_idx   = 3'd0;
  localparam logic [csr_addr_width-1:0] csr_b_ptr_idx   = 3'd1;
  localparam logic [csr_addr_width-1:0] csr_len_idx     = 3'd2;
  localparam logic [csr_addr_width-1:0] csr_start_idx   = 3'd3;
  localparam logic [csr_addr_width-1:0] csr_status_idx  = 3'd4;
  localparam logic [csr_addr_width-1:0] csr_res_ptr_idx = 3'd5;

  // status word fields
  localparam int status_idle_bit = 0;

  typedef logic [csr_data_width-1:0] csr_word_t;

endpackage

`default_nettype wire

/* hw/vdp_core_pkg.sv */
`default_nettype none

package vdp_core_pkg;

  // datapath
  localparam int elem_width     = 64;
  localparam int lane_count     = 8;
  localparam int lane_idx_width = 3;

  // only the low bits of the length register matter
  localparam int len_width = 4;

  // memory side, byte addressed
  localparam int mem_addr_width = 32;
  localparam int elem_bytes     = 8;

  typedef logic [elem_width-1:0]     elem_t;
  typedef logic [mem_addr_width-1:0] mem_addr_t;

  typedef enum logic [2:0] {
    idle,
    fetch_a,
    fetch_b,
    compute,
    store
  } seq_state_e;

endpackage

`default_nettype wire

/* hw/vdp_csr_regs.sv */
`default_nettype none

module vdp_csr_regs (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic                                       csr_cyc_i,
  input  logic                                       csr_stb_i,
  input  logic                                       csr_we_i,
  input  logic [vdp_bus_pkg::csr_addr_width-1:0]     csr_adr_i,
  input  vdp_bus_pkg::csr_word_t                     csr_dat_i,
  input  logic                                       idle_i,
  output vdp_bus_pkg::csr_word_t                     csr_dat_o,
  output logic                                       csr_ack_o,
  output logic                                       start_o,
  output vdp_core_pkg::mem_addr_t                    a_ptr_o,
  output vdp_core_pkg::mem_addr_t                    b_ptr_o,
  output logic [vdp_core_pkg::len_width-1:0]         len_o,
  output vdp_core_pkg::mem_addr_t                    res_ptr_o
);

  vdp_bus_pkg::csr_word_t a_ptr_r;
  vdp_bus_pkg::csr_word_t b_ptr_r;
  vdp_bus_pkg::csr_word_t len_r;
  vdp_bus_pkg::csr_word_t start_r;
  vdp_bus_pkg::csr_word_t res_ptr_r;
  vdp_bus_pkg::csr_word_t status_w;
  vdp_bus_pkg::csr_word_t rd_data;
  logic                   req;
  logic                   fired_r;
  logic                   idle_q;
  logic                   run_done;

  // new request only, ack cycle is not a second request
  assign req = csr_cyc_i & csr_stb_i & ~csr_ack_o;

  always_comb begin
    status_w = '0;
    status_w[vdp_bus_pkg::status_idle_bit] = idle_i;
  end

  always_comb begin
    case (csr_adr_i)
      vdp_bus_pkg::csr_a_ptr_idx:   rd_data = a_ptr_r;
      vdp_bus_pkg::csr_b_ptr_idx:   rd_data = b_ptr_r;
      vdp_bus_pkg::csr_len_idx:     rd_data = len_r;
      vdp_bus_pkg::csr_start_idx:   rd_data = start_r;
      vdp_bus_pkg::csr_status_idx:  rd_data = status_w;
      vdp_bus_pkg::csr_res_ptr_idx: rd_data = res_ptr_r;
      default:                      rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      csr_ack_o <= 1'b0;
    end else begin
      csr_ack_o <= req;
    end
  end

  // read data lines up with ack
  always_ff @(posedge clk_i) begin
    if (req && !csr_we_i) begin
      csr_dat_o <= rd_data;
    end
  end

  // first cycle of a nonzero start while the sequencer is idle
  assign start_o  = (start_r != '0) & idle_i & ~fired_r;
  assign run_done = fired_r & idle_i & ~idle_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_ptr_r   <= '0;
      b_ptr_r   <= '0;
      len_r     <= '0;
      start_r   <= '0;
      res_ptr_r <= '0;
      fired_r   <= 1'b0;
      idle_q    <= 1'b1;
    end else begin
      idle_q <= idle_i;
      if (start_o) begin
        fired_r <= 1'b1;
      end
      // run finished, drop the start request
      if (run_done) begin
        start_r <= '0;
        fired_r <= 1'b0;
      end
      if (req && csr_we_i) begin
        case (csr_adr_i)
          vdp_bus_pkg::csr_a_ptr_idx:   a_ptr_r   <= csr_dat_i;
          vdp_bus_pkg::csr_b_ptr_idx:   b_ptr_r   <= csr_dat_i;
          vdp_bus_pkg::csr_len_idx:     len_r     <= csr_dat_i;
          vdp_bus_pkg::csr_res_ptr_idx: res_ptr_r <= csr_dat_i;
          vdp_bus_pkg::csr_start_idx: begin
            if (idle_i && !fired_r) begin
              start_r <= csr_dat_i;
            end
          end
          default: ;
        endcase
      end
    end
  end

  assign a_ptr_o   = a_ptr_r[vdp_core_pkg::mem_addr_width-1:0];
  assign b_ptr_o   = b_ptr_r[vdp_core_pkg::mem_addr_width-1:0];
  assign len_o     = len_r[vdp_core_pkg::len_width-1:0];
  assign res_ptr_o = res_ptr_r[vdp_core_pkg::mem_addr_width-1:0];

endmodule

`default_nettype wire

/* hw/vdp_sequencer.sv */
`default_nettype none

module vdp_sequencer (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        start_i,
  input  vdp_core_pkg::mem_addr_t                     a_ptr_i,
  input  vdp_core_pkg::mem_addr_t                     b_ptr_i,
  input  logic [vdp_core_pkg::len_width-1:0]          len_i,
  input  vdp_core_pkg::mem_addr_t                     res_ptr_i,
  input  vdp_core_pkg::elem_t                         sum_i,
  input  vdp_core_pkg::elem_t                         mem_dat_i,
  input  logic                                        mem_ack_i,
  output logic                                        idle_o,
  output logic                                        mem_cyc_o,
  output logic                                        mem_stb_o,
  output logic                                        mem_we_o,
  output vdp_core_pkg::mem_addr_t                     mem_adr_o,
  output vdp_core_pkg::elem_t                         mem_dat_o,
  output logic                                        clear_o,
  output logic                                        load_a_o,
  output logic                                        load_b_o,
  output logic [vdp_core_pkg::lane_idx_width-1:0]     lane_o,
  output vdp_core_pkg::elem_t                         elem_o,
  output logic                                        compute_o
);

  vdp_core_pkg::seq_state_e                 state_r;
  logic                                     cyc_r;
  logic [vdp_core_pkg::len_width-1:0]       cnt_r;
  logic [vdp_core_pkg::len_width-1:0]       cnt_next;
  logic [vdp_core_pkg::len_width-1:0]       len_r;
  vdp_core_pkg::mem_addr_t                  b_ptr_r;
  vdp_core_pkg::mem_addr_t                  res_ptr_r;
  vdp_core_pkg::mem_addr_t                  addr_r;
  logic                                     acked;
  logic                                     last_elem;

  assign acked     = cyc_r & mem_ack_i;
  assign cnt_next  = cnt_r + 1'b1;
  assign last_elem = (cnt_next == len_r);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= vdp_core_pkg::idle;
      cyc_r   <= 1'b0;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        vdp_core_pkg::idle: begin
          if (start_i) begin
            state_r <= vdp_core_pkg::fetch_a;
            cyc_r   <= 1'b1;
            cnt_r   <= '0;
          end
        end
        vdp_core_pkg::fetch_a: begin
          // one dead cycle on the bus between reads
          if (acked) begin
            cyc_r <= 1'b0;
            if (last_elem) begin
              state_r <= vdp_core_pkg::fetch_b;
              cnt_r   <= '0;
            end else begin
              cnt_r <= cnt_next;
            end
          end else begin
            cyc_r <= 1'b1;
          end
        end
        vdp_core_pkg::fetch_b: begin
          if (acked) begin
            cyc_r <= 1'b0;
            if (last_elem) begin
              state_r <= vdp_core_pkg::compute;
              cnt_r   <= '0;
            end else begin
              cnt_r <= cnt_next;
            end
          end else begin
            cyc_r <= 1'b1;
          end
        end
        vdp_core_pkg::compute: begin
          // sum is registered by the time the store goes out
          state_r <= vdp_core_pkg::store;
          cyc_r   <= 1'b1;
        end
        vdp_core_pkg::store: begin
          if (acked) begin
            state_r <= vdp_core_pkg::idle;
            cyc_r   <= 1'b0;
          end
        end
        default: state_r <= vdp_core_pkg::idle;
      endcase
    end
  end

  // pointers and address walk
  always_ff @(posedge clk_i) begin
    if (state_r == vdp_core_pkg::idle && start_i) begin
      addr_r    <= a_ptr_i;
      len_r     <= len_i;
      b_ptr_r   <= b_ptr_i;
      res_ptr_r <= res_ptr_i;
    end else if (acked && state_r == vdp_core_pkg::fetch_a && last_elem) begin
      addr_r <= b_ptr_r;
    end else if (acked && state_r != vdp_core_pkg::store) begin
      addr_r <= addr_r + vdp_core_pkg::mem_addr_t'(vdp_core_pkg::elem_bytes);
    end else if (state_r == vdp_core_pkg::compute) begin
      addr_r <= res_ptr_r;
    end
  end

  assign idle_o    = (state_r == vdp_core_pkg::idle);
  assign clear_o   = idle_o & start_i;
  assign load_a_o  = acked & (state_r == vdp_core_pkg::fetch_a);
  assign load_b_o  = acked & (state_r == vdp_core_pkg::fetch_b);
  assign lane_o    = cnt_r[vdp_core_pkg::lane_idx_width-1:0];
  assign elem_o    = mem_dat_i;
  assign compute_o = (state_r == vdp_core_pkg::compute);

  assign mem_cyc_o = cyc_r;
  assign mem_stb_o = cyc_r;
  assign mem_we_o  = (state_r == vdp_core_pkg::store);
  assign mem_adr_o = addr_r;
  assign mem_dat_o = sum_i;

endmodule

`default_nettype wire

/* hw/vdp_dot_unit.sv */
`default_nettype none

module vdp_dot_unit (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic                                       clear_i,
  input  logic                                       load_a_i,
  input  logic                                       load_b_i,
  input  logic [vdp_core_pkg::lane_idx_width-1:0]    lane_i,
  input  vdp_core_pkg::elem_t                        elem_i,
  input  logic                                       compute_i,
  output vdp_core_pkg::elem_t                        sum_o
);

  vdp_core_pkg::elem_t a_r [vdp_core_pkg::lane_count];
  vdp_core_pkg::elem_t b_r [vdp_core_pkg::lane_count];
  vdp_core_pkg::elem_t prod [vdp_core_pkg::lane_count];
  vdp_core_pkg::elem_t sum_l1 [vdp_core_pkg::lane_count/2];
  vdp_core_pkg::elem_t sum_l2 [vdp_core_pkg::lane_count/4];
  vdp_core_pkg::elem_t total;

  // untouched lanes stay zero and add nothing
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      for (int i = 0; i < vdp_core_pkg::lane_count; i++) begin
        a_r[i] <= '0;
        b_r[i] <= '0;
      end
    end else begin
      if (load_a_i) begin
        a_r[lane_i] <= elem_i;
      end
      if (load_b_i) begin
        b_r[lane_i] <= elem_i;
      end
    end
  end

  // low 64 bits only, wraps mod 2^64
  for (genvar i = 0; i < vdp_core_pkg::lane_count; i++) begin : g_mul
    assign prod[i] = a_r[i] * b_r[i];
  end

  for (genvar i = 0; i < vdp_core_pkg::lane_count/2; i++) begin : g_lvl1
    assign sum_l1[i] = prod[2*i] + prod[2*i+1];
  end

  for (genvar i = 0; i < vdp_core_pkg::lane_count/4; i++) begin : g_lvl2
    assign sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
  end

  assign total = sum_l2[0] + sum_l2[1];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sum_o <= '0;
    end else if (compute_i) begin
      sum_o <= total;
    end
  end

endmodule

`default_nettype wire

/* hw/vdp_top.sv */
`default_nettype none

module vdp_top (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic                                       csr_cyc_i,
  input  logic                                       csr_stb_i,
  input  logic                                       csr_we_i,
  input  logic [vdp_bus_pkg::csr_addr_width-1:0]     csr_adr_i,
  input  vdp_bus_pkg::csr_word_t                     csr_dat_i,
  output vdp_bus_pkg::csr_word_t                     csr_dat_o,
  output logic                                       csr_ack_o,
  output logic                                       mem_cyc_o,
  output logic                                       mem_stb_o,
  output logic                                       mem_we_o,
  output vdp_core_pkg::mem_addr_t                    mem_adr_o,
  output vdp_core_pkg::elem_t                        mem_dat_o,
  input  vdp_core_pkg::elem_t                        mem_dat_i,
  input  logic                                       mem_ack_i
);

  logic                                     start;
  logic                                     idle;
  vdp_core_pkg::mem_addr_t                  a_ptr;
  vdp_core_pkg::mem_addr_t                  b_ptr;
  vdp_core_pkg::mem_addr_t                  res_ptr;
  logic [vdp_core_pkg::len_width-1:0]       len;
  logic                                     clear;
  logic                                     load_a;
  logic                                     load_b;
  logic                                     compute;
  logic [vdp_core_pkg::lane_idx_width-1:0]  lane;
  vdp_core_pkg::elem_t                      elem;
  vdp_core_pkg::elem_t                      sum;

  vdp_csr_regs i_csr (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .csr_cyc_i (csr_cyc_i),
    .csr_stb_i (csr_stb_i),
    .csr_we_i  (csr_we_i),
    .csr_adr_i (csr_adr_i),
    .csr_dat_i (csr_dat_i),
    .idle_i    (idle),
    .csr_dat_o (csr_dat_o),
    .csr_ack_o (csr_ack_o),
    .start_o   (start),
    .a_ptr_o   (a_ptr),
    .b_ptr_o   (b_ptr),
    .len_o     (len),
    .res_ptr_o (res_ptr)
  );

  vdp_sequencer i_seq (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .start_i   (start),
    .a_ptr_i   (a_ptr),
    .b_ptr_i   (b_ptr),
    .len_i     (len),
    .res_ptr_i (res_ptr),
    .sum_i     (sum),
    .mem_dat_i (mem_dat_i),
    .mem_ack_i (mem_ack_i),
    .idle_o    (idle),
    .mem_cyc_o (mem_cyc_o),
    .mem_stb_o (mem_stb_o),
    .mem_we_o  (mem_we_o),
    .mem_adr_o (mem_adr_o),
    .mem_dat_o (mem_dat_o),
    .clear_o   (clear),
    .load_a_o  (load_a),
    .load_b_o  (load_b),
    .lane_o    (lane),
    .elem_o    (elem),
    .compute_o (compute)
  );

  vdp_dot_unit i_dot (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .clear_i   (clear),
    .load_a_i  (load_a),
    .load_b_i  (load_b),
    .lane_i    (lane),
    .elem_i    (elem),
    .compute_i (compute),
    .sum_o     (sum)
  );

endmodule

`default_nettype wire

/* dv/vdp_sva.sv */
`default_nettype none

module vdp_sva (
  input logic                                 clk_i,
  input logic                                 reset_i,
  input logic                                 csr_cyc_i,
  input logic                                 csr_stb_i,
  input logic                                 mem_cyc_o,
  input logic                                 mem_stb_o,
  input logic                                 mem_ack_i,
  input vdp_core_pkg::mem_addr_t              mem_adr_o,
  input logic                                 start,
  input logic [vdp_core_pkg::len_width-1:0]   len
);

  csr_stb_in_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
    csr_stb_i |-> csr_cyc_i)
    else $error("host stb without cyc");

  // cycle ends right after the slave answers
  mem_drop_after_ack: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_ack_i |=> (!mem_cyc_o && !mem_stb_o))
    else $error("memory cycle held after ack");

  // address held until the slave answers
  mem_adr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_stb_o && !mem_ack_i) |=> $stable(mem_adr_o))
    else $error("memory address changed before ack");

  start_len_ok: assert property (@(posedge clk_i) disable iff (reset_i)
    start |-> (len != 0 && len <= 8))
    else $error("start with unsupported length");

endmodule

bind vdp_top vdp_sva i_sva (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .csr_cyc_i (csr_cyc_i),
  .csr_stb_i (csr_stb_i),
  .mem_cyc_o (mem_cyc_o),
  .mem_stb_o (mem_stb_o),
  .mem_ack_i (mem_ack_i),
  .mem_adr_o (mem_adr_o),
  .start     (start),
  .len       (len)
);

`default_nettype wire

/* dv/vdp_tb.sv */
`default_nettype none

module vdp_tb;

  localparam int max_tests = 16;
  localparam int mem_words = 256;

  logic                                    clk_i;
  logic                                    reset_i;
  logic                                    csr_cyc;
  logic                                    csr_stb;
  logic                                    csr_we;
  logic [vdp_bus_pkg::csr_addr_width-1:0]  csr_adr;
  vdp_bus_pkg::csr_word_t                  csr_wdat;
  vdp_bus_pkg::csr_word_t                  csr_rdat;
  logic                                    csr_ack;
  logic                                    mem_cyc;
  logic                                    mem_stb;
  logic                                    mem_we;
  vdp_core_pkg::mem_addr_t                 mem_adr;
  vdp_core_pkg::elem_t                     mem_wdat;
  vdp_core_pkg::elem_t                     mem_rdat;
  logic                                    mem_ack;

  // memory model state
  vdp_core_pkg::elem_t     mem [mem_words];
  logic                    mem_busy;
  int                      mem_wait;
  int                      mem_delay;
  int                      store_count;
  vdp_core_pkg::mem_addr_t store_adr;
  vdp_core_pkg::elem_t     store_dat;
  int                      seed;

  // test table
  logic [8*24-1:0]         t_name [max_tests];
  vdp_core_pkg::mem_addr_t t_a_ptr [max_tests];
  vdp_core_pkg::mem_addr_t t_b_ptr [max_tests];
  vdp_core_pkg::mem_addr_t t_res_ptr [max_tests];
  vdp_bus_pkg::csr_word_t  t_len [max_tests];
  vdp_core_pkg::elem_t     t_a [max_tests][8];
  vdp_core_pkg::elem_t     t_b [max_tests][8];
  vdp_core_pkg::elem_t     t_exp [max_tests];
  int                      num_tests;
  int                      cycles;
  int                      cycle_limit;

  vdp_top i_dut (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .csr_cyc_i (csr_cyc),
    .csr_stb_i (csr_stb),
    .csr_we_i  (csr_we),
    .csr_adr_i (csr_adr),
    .csr_dat_i (csr_wdat),
    .csr_dat_o (csr_rdat),
    .csr_ack_o (csr_ack),
    .mem_cyc_o (mem_cyc),
    .mem_stb_o (mem_stb),
    .mem_we_o  (mem_we),
    .mem_adr_o (mem_adr),
    .mem_dat_o (mem_wdat),
    .mem_dat_i (mem_rdat),
    .mem_ack_i (mem_ack)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: no result after %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  // Wishbone memory slave, acks 0 to 3 cycles after the request is seen
  always @(posedge clk_i) begin
    if (reset_i) begin
      mem_ack  <= 1'b0;
      mem_busy <= 1'b0;
      mem_wait <= 0;
    end else if (mem_ack) begin
      mem_ack  <= 1'b0;
      mem_busy <= 1'b0;
    end else if (mem_cyc && mem_stb) begin
      if (!mem_busy) begin
        mem_delay = $unsigned($random(seed)) % 4;
        mem_busy <= 1'b1;
        mem_wait <= mem_delay;
      end else if (mem_wait != 0) begin
        mem_wait <= mem_wait - 1;
      end else begin
        mem_ack <= 1'b1;
        if (mem_we) begin
          store_count <= store_count + 1;
          store_adr   <= mem_adr;
          store_dat   <= mem_wdat;
        end else begin
          mem_rdat <= mem[(mem_adr >> 3) % mem_words];
        end
      end
    end
  end

  task automatic check_word(input string label, input vdp_bus_pkg::csr_word_t exp_val,
                            input vdp_bus_pkg::csr_word_t act_val);
    if (exp_val !== act_val) begin
      $display("FAILED %s: expected %h, actual %h", label, exp_val, act_val);
      $display("Result: FAILED");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_elem(input string label, input vdp_core_pkg::elem_t exp_val,
                            input vdp_core_pkg::elem_t act_val);
    if (exp_val !== act_val) begin
      $display("FAILED %s: expected %h, actual %h", label, exp_val, act_val);
      $display("Result: FAILED");
      $fatal(1, "element mismatch");
    end
  endtask

  task automatic bus_write(input logic [2:0] adr, input vdp_bus_pkg::csr_word_t dat);
    @(posedge clk_i);
    csr_cyc  <= 1'b1;
    csr_stb  <= 1'b1;
    csr_we   <= 1'b1;
    csr_adr  <= adr;
    csr_wdat <= dat;
    do @(negedge clk_i); while (!csr_ack);
    @(posedge clk_i);
    csr_cyc <= 1'b0;
    csr_stb <= 1'b0;
    csr_we  <= 1'b0;
  endtask

  task automatic bus_read(input logic [2:0] adr, output vdp_bus_pkg::csr_word_t dat);
    @(posedge clk_i);
    csr_cyc <= 1'b1;
    csr_stb <= 1'b1;
    csr_we  <= 1'b0;
    csr_adr <= adr;
    do @(negedge clk_i); while (!csr_ack);
    dat = csr_rdat;
    @(posedge clk_i);
    csr_cyc <= 1'b0;
    csr_stb <= 1'b0;
  endtask

  task automatic read_tests();
    int                  fd;
    int                  n;
    string               line;
    logic [8*24-1:0]     nm;
    logic [31:0]         ap, bp, rp;
    logic [63:0]         ln, ex;
    logic [63:0]         a0, a1, a2, a3, a4, a5, a6, a7;
    logic [63:0]         b0, b1, b2, b3, b4, b5, b6, b7;
    fd = $fopen("dv/vdp_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      $display("Result: FAILED");
      $fatal(1, "missing test data");
    end
    num_tests = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  nm, ap, bp, rp, ln, a0, a1, a2, a3, a4, a5, a6, a7,
                  b0, b1, b2, b3, b4, b5, b6, b7, ex);
      if (n != 22 || num_tests == max_tests) begin
        $display("malformed or extra line in the test data file");
        $display("Result: FAILED");
        $fatal(1, "bad test data");
      end
      t_name[num_tests]    = nm;
      t_a_ptr[num_tests]   = ap;
      t_b_ptr[num_tests]   = bp;
      t_res_ptr[num_tests] = rp;
      t_len[num_tests]     = ln;
      t_exp[num_tests]     = ex;
      t_a[num_tests] = '{a0, a1, a2, a3, a4, a5, a6, a7};
      t_b[num_tests] = '{b0, b1, b2, b3, b4, b5, b6, b7};
      num_tests++;
    end
    $fclose(fd);
  endtask

  task automatic run_test(input int t);
    string                  nm;
    vdp_bus_pkg::csr_word_t rd;
    int                     stores_before;
    nm = $sformatf("%0s", t_name[t]);
    // junk past len is loaded too
    for (int k = 0; k < 8; k++) begin
      mem[(t_a_ptr[t] >> 3) + k] = t_a[t][k];
      mem[(t_b_ptr[t] >> 3) + k] = t_b[t][k];
    end
    bus_write(vdp_bus_pkg::csr_a_ptr_idx, 64'(t_a_ptr[t]));
    bus_write(vdp_bus_pkg::csr_b_ptr_idx, 64'(t_b_ptr[t]));
    bus_write(vdp_bus_pkg::csr_len_idx, t_len[t]);
    bus_write(vdp_bus_pkg::csr_res_ptr_idx, 64'(t_res_ptr[t]));
    bus_read(vdp_bus_pkg::csr_a_ptr_idx, rd);
    check_word({nm, " a_ptr"}, 64'(t_a_ptr[t]), rd);
    bus_read(vdp_bus_pkg::csr_b_ptr_idx, rd);
    check_word({nm, " b_ptr"}, 64'(t_b_ptr[t]), rd);
    bus_read(vdp_bus_pkg::csr_len_idx, rd);
    check_word({nm, " len"}, t_len[t], rd);
    bus_read(vdp_bus_pkg::csr_res_ptr_idx, rd);
    check_word({nm, " res_ptr"}, 64'(t_res_ptr[t]), rd);
    stores_before = store_count;
    bus_write(vdp_bus_pkg::csr_start_idx, 64'd1);
    // poll until the run is over
    do bus_read(vdp_bus_pkg::csr_status_idx, rd); while (!rd[0]);
    check_word({nm, " store count"}, 64'(stores_before + 1), 64'(store_count));
    check_word({nm, " store address"}, 64'(t_res_ptr[t]), 64'(store_adr));
    check_elem({nm, " result"}, t_exp[t], store_dat);
    bus_read(vdp_bus_pkg::csr_start_idx, rd);
    check_word({nm, " start after run"}, 64'd0, rd);
  endtask

  initial begin
    vdp_bus_pkg::csr_word_t rd;
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    csr_cyc     = 1'b0;
    csr_stb     = 1'b0;
    csr_we      = 1'b0;
    csr_adr     = '0;
    csr_wdat    = '0;
    mem_rdat    = '0;
    mem_ack     = 1'b0;
    mem_busy    = 1'b0;
    store_count = 0;
    store_adr   = '0;
    store_dat   = '0;
    cycles      = 0;
    cycle_limit = 1000;
    seed        = 32'h10f4b2c2;
    for (int w = 0; w < mem_words; w++) begin
      mem[w] = {32'h0bad0000 + 32'(w), ~32'(w)};
    end
    read_tests();
    cycle_limit = num_tests * 200 + 100;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    bus_read(vdp_bus_pkg::csr_status_idx, rd);
    check_word("reset status", 64'd1, rd);
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    if (num_tests == 0) begin
      $display("Result: FAILED");
      $fatal(1, "no tests found");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* dv/vdp_tests.txt */
# name a_ptr b_ptr res_ptr len a0..a7 b0..b7 expected, all hex
# words past len are junk and must not affect the result
t_full8 100 200 300 8 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 cc
t_short3 140 240 308 3 2 3 4 aa bb cc dd ee 5 6 7 11 12 13 14 15 38
t_wrap 180 280 310 2 8000000000000000 ffffffffffffffff 77 66 55 44 33 22 2 ffffffffffffffff 99 88 77 66 55 44 1
t_big 1c0 2c0 318 8 ffffffffffffffff ffffffffffffffff ffffffffffffffff ffffffffffffffff ffffffffffffffff ffffffffffffffff ffffffffffffffff ffffffffffffffff 1 2 3 4 5 6 7 8 ffffffffffffffdc
t_len1 100 200 320 1 7 a1 a2 a3 a4 a5 a6 a7 9 b1 b2 b3 b4 b5 b6 b7 3f
t_short5 400 500 600 5 1 1 1 1 1 c1 c2 c3 10 20 30 40 50 d1 d2 d3 f0

/* sim.f */
hw/vdp_bus_pkg.sv
hw/vdp_core_pkg.sv
hw/vdp_csr_regs.sv
hw/vdp_sequencer.sv
hw/vdp_dot_unit.sv
hw/vdp_top.sv
dv/vdp_sva.sv
dv/vdp_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= vdp_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
